// ==== design/wbPkg.sv ====
`default_nettype none

package wbPkg;

    // where the written-back result comes from.
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wbSrcE;

    // register index and csr address widths.
    localparam int REG_IDX_W = 5;
    localparam int CSR_ADDR_W = 12;

    // machine csrs held by the csr file.
    localparam logic [11:0] CSR_MTVEC = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC = 12'h341;

endpackage

`default_nettype wire

// ==== design/writebackStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module writebackStage #(
    parameter int XLEN = 64
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          inValid,
    output logic                          inReady,
    input  logic [XLEN-1:0]               inPc,
    input  logic [31:0]                   inInstr,
    input  logic [wbPkg::REG_IDX_W-1:0]   inRd,
    input  wbPkg::wbSrcE                  inSrc,
    input  logic                          inWriteBack,
    input  logic [XLEN-1:0]               inAluOut,
    input  logic [XLEN-1:0]               inMemOut,
    input  logic [XLEN-1:0]               inPcPlus4,
    input  logic                          inIsMem,
    input  logic [XLEN-1:0]               inMemAddr,
    input  logic                          inCsrWrite,
    input  logic [wbPkg::CSR_ADDR_W-1:0]  inCsrAddr,
    input  logic [XLEN-1:0]               inCsrData,

    output logic                          commitValid,
    input  logic                          commitReady,
    output logic [XLEN-1:0]               commitPc,
    output logic [31:0]                   commitInstr,
    output logic                          commitIsWb,
    output logic [wbPkg::REG_IDX_W-1:0]   commitRd,
    output logic [XLEN-1:0]               commitData,
    output logic                          commitIsMem,
    output logic [XLEN-1:0]               commitMemAddr,

    output logic                          wbEn,
    output logic [wbPkg::REG_IDX_W-1:0]   wbRd,
    output logic [XLEN-1:0]               wbData,
    output logic                          csrWe,
    output logic [wbPkg::CSR_ADDR_W-1:0]  csrWaddr,
    output logic [XLEN-1:0]               csrWdata
);

    import wbPkg::*;

    logic            accept;
    logic [XLEN-1:0] selData;

    // slot is free, or its record leaves this cycle.
    assign inReady = !commitValid || commitReady;
    assign accept = inValid && inReady;

    // result select.
    always_comb begin
        case (inSrc)
            WB_ALU:  selData = inAluOut;
            WB_MEM:  selData = inMemOut;
            WB_PC4:  selData = inPcPlus4;
            default: selData = inAluOut;
        endcase
    end

    // control state.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commitValid <= 1'b0;
            wbEn <= 1'b0;
            csrWe <= 1'b0;
        end else begin
            // write pulses last one cycle per accepted entry.
            wbEn <= accept && inWriteBack;
            csrWe <= accept && inCsrWrite;
            if (accept) begin
                commitValid <= 1'b1;
            end else if (commitReady) begin
                commitValid <= 1'b0;
            end
        end
    end

    // commit record and csr write payload.
    always_ff @(posedge clk) begin
        if (accept) begin
            commitPc <= inPc;
            commitInstr <= inInstr;
            commitIsWb <= inWriteBack;
            commitRd <= inRd;
            commitData <= selData;
            commitIsMem <= inIsMem;
            commitMemAddr <= inMemAddr;
            csrWaddr <= inCsrAddr;
            csrWdata <= inCsrData;
        end
    end

    // register write shares the commit record.
    assign wbRd = commitRd;
    assign wbData = commitData;

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile #(
    parameter int XLEN = 64
) (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         wbEn,
    input  logic [wbPkg::REG_IDX_W-1:0]  wbRd,
    input  logic [XLEN-1:0]              wbData,

    input  logic [wbPkg::REG_IDX_W-1:0]  rsAddr,
    output logic [XLEN-1:0]              rsData
);

    import wbPkg::*;

    localparam int NumRegs = 1 << REG_IDX_W;

    // x0 has no storage.
    logic [XLEN-1:0] regs [1:NumRegs-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbRd != '0)) begin
            regs[wbRd] <= wbData;
        end
    end

    always_comb begin
        if (rsAddr == '0) begin
            rsData = '0;
        end else begin
            rsData = regs[rsAddr];
        end
    end

endmodule

`default_nettype wire

// ==== design/csrFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrFile #(
    parameter int XLEN = 64
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          csrWe,
    input  logic [wbPkg::CSR_ADDR_W-1:0]  csrWaddr,
    input  logic [XLEN-1:0]               csrWdata,

    input  logic [wbPkg::CSR_ADDR_W-1:0]  csrRaddr,
    output logic [XLEN-1:0]               csrRdata
);

    import wbPkg::*;

    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;

    logic wrMtvec;
    logic wrMscratch;
    logic wrMepc;

    // write decode.
    assign wrMtvec = csrWe && (csrWaddr == CSR_MTVEC);
    assign wrMscratch = csrWe && (csrWaddr == CSR_MSCRATCH);
    assign wrMepc = csrWe && (csrWaddr == CSR_MEPC);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtvec <= '0;
            mscratch <= '0;
            mepc <= '0;
        end else begin
            // mode bits stay zero in direct mode.
            if (wrMtvec) begin
                mtvec <= {csrWdata[XLEN-1:2], 2'b00};
            end
            if (wrMscratch) begin
                mscratch <= csrWdata;
            end
            // the pc stays even without compressed instructions.
            if (wrMepc) begin
                mepc <= {csrWdata[XLEN-1:1], 1'b0};
            end
        end
    end

    // unknown addresses read zero.
    always_comb begin
        case (csrRaddr)
            CSR_MTVEC:    csrRdata = mtvec;
            CSR_MSCRATCH: csrRdata = mscratch;
            CSR_MEPC:     csrRdata = mepc;
            default:      csrRdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/wbTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbTop #(
    parameter int XLEN = 64
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          inValid,
    output logic                          inReady,
    input  logic [XLEN-1:0]               inPc,
    input  logic [31:0]                   inInstr,
    input  logic [wbPkg::REG_IDX_W-1:0]   inRd,
    input  wbPkg::wbSrcE                  inSrc,
    input  logic                          inWriteBack,
    input  logic [XLEN-1:0]               inAluOut,
    input  logic [XLEN-1:0]               inMemOut,
    input  logic [XLEN-1:0]               inPcPlus4,
    input  logic                          inIsMem,
    input  logic [XLEN-1:0]               inMemAddr,
    input  logic                          inCsrWrite,
    input  logic [wbPkg::CSR_ADDR_W-1:0]  inCsrAddr,
    input  logic [XLEN-1:0]               inCsrData,

    output logic                          commitValid,
    input  logic                          commitReady,
    output logic [XLEN-1:0]               commitPc,
    output logic [31:0]                   commitInstr,
    output logic                          commitIsWb,
    output logic [wbPkg::REG_IDX_W-1:0]   commitRd,
    output logic [XLEN-1:0]               commitData,
    output logic                          commitIsMem,
    output logic [XLEN-1:0]               commitMemAddr,

    input  logic [wbPkg::REG_IDX_W-1:0]   rsAddr,
    output logic [XLEN-1:0]               rsData,
    input  logic [wbPkg::CSR_ADDR_W-1:0]  csrRaddr,
    output logic [XLEN-1:0]               csrRdata
);

    import wbPkg::*;

    // write ports from the stage.
    logic                  wbEn;
    logic [REG_IDX_W-1:0]  wbRd;
    logic [XLEN-1:0]       wbData;
    logic                  csrWe;
    logic [CSR_ADDR_W-1:0] csrWaddr;
    logic [XLEN-1:0]       csrWdata;

    writebackStage #(
        .XLEN(XLEN)
    ) stage0 (
        .clk           (clk),
        .rst           (rst),
        .inValid       (inValid),
        .inReady       (inReady),
        .inPc          (inPc),
        .inInstr       (inInstr),
        .inRd          (inRd),
        .inSrc         (inSrc),
        .inWriteBack   (inWriteBack),
        .inAluOut      (inAluOut),
        .inMemOut      (inMemOut),
        .inPcPlus4     (inPcPlus4),
        .inIsMem       (inIsMem),
        .inMemAddr     (inMemAddr),
        .inCsrWrite    (inCsrWrite),
        .inCsrAddr     (inCsrAddr),
        .inCsrData     (inCsrData),
        .commitValid   (commitValid),
        .commitReady   (commitReady),
        .commitPc      (commitPc),
        .commitInstr   (commitInstr),
        .commitIsWb    (commitIsWb),
        .commitRd      (commitRd),
        .commitData    (commitData),
        .commitIsMem   (commitIsMem),
        .commitMemAddr (commitMemAddr),
        .wbEn          (wbEn),
        .wbRd          (wbRd),
        .wbData        (wbData),
        .csrWe         (csrWe),
        .csrWaddr      (csrWaddr),
        .csrWdata      (csrWdata)
    );

    regFile #(
        .XLEN(XLEN)
    ) regs0 (
        .clk    (clk),
        .rst    (rst),
        .wbEn   (wbEn),
        .wbRd   (wbRd),
        .wbData (wbData),
        .rsAddr (rsAddr),
        .rsData (rsData)
    );

    csrFile #(
        .XLEN(XLEN)
    ) csrs0 (
        .clk      (clk),
        .rst      (rst),
        .csrWe    (csrWe),
        .csrWaddr (csrWaddr),
        .csrWdata (csrWdata),
        .csrRaddr (csrRaddr),
        .csrRdata (csrRdata)
    );

endmodule

`default_nettype wire

// ==== tests/tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk
);

    initial clk = 1'b0;

    // 4 ns period.
    always #2 clk = ~clk;

endmodule

`default_nettype wire

// ==== tests/wbAsserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbAsserts #(
    parameter int XLEN = 64
) (
    input logic                        clk,
    input logic                        rst,
    input logic                        inValid,
    input logic                        inReady,
    input logic                        commitValid,
    input logic                        commitReady,
    input logic [XLEN-1:0]             commitPc,
    input logic [XLEN-1:0]             commitData,
    input logic [wbPkg::REG_IDX_W-1:0] commitRd,
    input logic                        commitIsWb,
    input logic                        wbEn,
    input logic                        csrWe
);

    // held record must not move.
    recordStable: assert property (@(posedge clk) disable iff (rst)
        commitValid && !commitReady |=> commitValid && $stable(commitPc)
            && $stable(commitData) && $stable(commitRd) && $stable(commitIsWb))
        else $error("commit record changed while stalled");

    // write pulses only right after an accept.
    wbPulse: assert property (@(posedge clk) disable iff (rst)
        (wbEn || csrWe) |-> commitValid && $past(inValid && inReady))
        else $error("write pulse outside first record cycle");

    // slot is full after an accept or a stalled record.
    readyRule: assert property (@(posedge clk) disable iff (rst)
        inReady == (commitReady
            || !$past((inValid && inReady) || (commitValid && !commitReady))))
        else $error("inReady does not follow slot state");

endmodule

bind writebackStage wbAsserts #(.XLEN(XLEN)) asserts0 (.*);

`default_nettype wire

// ==== tests/wbTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbTb;

    import wbPkg::*;

    localparam int XLEN = 64;
    localparam int LIMIT = 200;

    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] instr;
        logic        isWb;
        logic [4:0]  rd;
        logic [63:0] data;
        logic        isMem;
        logic [63:0] memAddr;
    } recT;

    logic clk;
    logic rst;
    logic inValid, inReady, inWriteBack, inIsMem, inCsrWrite;
    logic [63:0] inPc, inAluOut, inMemOut, inPcPlus4, inMemAddr, inCsrData;
    logic [31:0] inInstr;
    logic [4:0] inRd;
    wbSrcE inSrc;
    logic [11:0] inCsrAddr;
    logic commitValid, commitReady, commitIsWb, commitIsMem;
    logic [63:0] commitPc, commitData, commitMemAddr;
    logic [31:0] commitInstr;
    logic [4:0] commitRd;
    logic [4:0] rsAddr;
    logic [63:0] rsData;
    logic [11:0] csrRaddr;
    logic [63:0] csrRdata;

    int errors = 0;
    logic stallMode = 1'b0;
    logic [31:0] dataSeed = 32'h833e_f2b8;
    logic [31:0] stallSeed = 32'h833e_f2b8 ^ 32'h5a5a_5a5a;
    logic [63:0] regModel [0:31];
    logic [63:0] mtvecM, mscratchM, mepcM;
    recT expQ[$];

    tbClock clkGen0 (.clk(clk));

    wbTop #(.XLEN(XLEN)) dut0 (.*);

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [63:0] csrModel(input logic [11:0] a);
        if (a == CSR_MTVEC) return mtvecM;
        else if (a == CSR_MSCRATCH) return mscratchM;
        else if (a == CSR_MEPC) return mepcM;
        return 64'h0;
    endfunction

    task automatic checkVal(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            errors++;
            $display("Mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic failTimeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        $display("%0d errors", errors);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic nextData(output logic [31:0] r);
        dataSeed = lcgNext(dataSeed);
        r = dataSeed;
    endtask

    // drives one entry and waits for its acceptance.
    task automatic sendEntry(input logic [63:0] pc, input logic [4:0] rd, input wbSrcE src,
                             input logic wb, input logic [63:0] alu, input logic [63:0] mem,
                             input logic csrW, input logic [11:0] csrA,
                             input logic [63:0] csrD, output int waits);
        recT r;
        waits = 0;
        inPc = pc;
        inInstr = pc[31:0] ^ 32'h0000_0013;
        inRd = rd;
        inSrc = src;
        inWriteBack = wb;
        inAluOut = alu;
        inMemOut = mem;
        inPcPlus4 = pc + 64'd4;
        inIsMem = (src == WB_MEM);
        inMemAddr = alu;
        inCsrWrite = csrW;
        inCsrAddr = csrA;
        inCsrData = csrD;
        inValid = 1'b1;
        @(negedge clk);
        while (!inReady) begin
            waits++;
            if (waits > LIMIT) failTimeout("inReady");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        inValid = 1'b0;
        r.pc = pc;
        r.instr = pc[31:0] ^ 32'h0000_0013;
        r.isWb = wb;
        r.rd = rd;
        if (src == WB_MEM) r.data = mem;
        else if (src == WB_PC4) r.data = pc + 64'd4;
        else r.data = alu;
        r.isMem = (src == WB_MEM);
        r.memAddr = alu;
        expQ.push_back(r);
        if (wb && rd != 5'd0) regModel[rd] = r.data;
        if (csrW && csrA == CSR_MTVEC) mtvecM = csrD & ~64'h3;
        if (csrW && csrA == CSR_MSCRATCH) mscratchM = csrD;
        if (csrW && csrA == CSR_MEPC) mepcM = csrD & ~64'h1;
    endtask

    task automatic checkReg(input logic [4:0] idx);
        rsAddr = idx;
        @(negedge clk);
        checkVal($sformatf("reg x%0d", idx), regModel[idx], rsData);
        @(posedge clk);
        #1;
    endtask

    task automatic checkCsr(input logic [11:0] a);
        csrRaddr = a;
        @(negedge clk);
        checkVal($sformatf("csr %h", a), csrModel(a), csrRdata);
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        int n;
        n = 0;
        commitReady = 1'b1;
        while (expQ.size() != 0) begin
            n++;
            if (n > LIMIT) failTimeout("commit records to drain");
            @(posedge clk);
            #1;
        end
    endtask

    // records seen here transfer at the next edge.
    always @(negedge clk) begin
        recT e;
        if (!rst && commitValid && commitReady) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("commit record arrived with nothing expected");
            end else begin
                e = expQ.pop_front();
                checkVal("commit pc", e.pc, commitPc);
                checkVal("commit instr", {32'h0, e.instr}, {32'h0, commitInstr});
                checkVal("commit isWb", {63'h0, e.isWb}, {63'h0, commitIsWb});
                checkVal("commit rd", {59'h0, e.rd}, {59'h0, commitRd});
                checkVal("commit data", e.data, commitData);
                checkVal("commit isMem", {63'h0, e.isMem}, {63'h0, commitIsMem});
                checkVal("commit memAddr", e.memAddr, commitMemAddr);
            end
        end
    end

    // random back-pressure.
    always @(posedge clk) begin
        #1;
        if (stallMode) begin
            stallSeed = lcgNext(stallSeed);
            commitReady = stallSeed[17] | stallSeed[9];
        end
    end

    initial begin
        int w;
        logic [31:0] r0, r1, r2;
        wbSrcE s;
        logic [11:0] ca;
        rst = 1'b1;
        inValid = 1'b0;
        {inPc, inAluOut, inMemOut, inPcPlus4, inMemAddr, inCsrData} = '0;
        {inInstr, inRd, inWriteBack, inIsMem, inCsrWrite, inCsrAddr} = '0;
        inSrc = WB_ALU;
        commitReady = 1'b1;
        rsAddr = '0;
        csrRaddr = '0;
        for (int i = 0; i < 32; i++) regModel[i] = '0;
        {mtvecM, mscratchM, mepcM} = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset state.
        checkVal("reset commitValid", 64'h0, {63'h0, commitValid});
        checkVal("reset inReady", 64'h1, {63'h0, inReady});
        for (int i = 0; i < 32; i++) checkReg(i[4:0]);
        checkCsr(CSR_MTVEC);
        checkCsr(CSR_MSCRATCH);
        checkCsr(CSR_MEPC);

        // result selection, then no-write and x0 entries.
        sendEntry(64'h1000, 5'd1, WB_ALU, 1'b1, 64'hA1, 64'hB1, 1'b0, 12'h0, 64'h0, w);
        @(posedge clk);
        #1;
        checkReg(5'd1);
        sendEntry(64'h1004, 5'd2, WB_MEM, 1'b1, 64'hA2, 64'hB2, 1'b0, 12'h0, 64'h0, w);
        @(posedge clk);
        #1;
        checkReg(5'd2);
        sendEntry(64'h1008, 5'd3, WB_PC4, 1'b1, 64'hA3, 64'hB3, 1'b0, 12'h0, 64'h0, w);
        @(posedge clk);
        #1;
        checkReg(5'd3);
        sendEntry(64'h100c, 5'd1, WB_ALU, 1'b0, 64'hEE, 64'h0, 1'b0, 12'h0, 64'h0, w);
        sendEntry(64'h1010, 5'd0, WB_ALU, 1'b1, 64'hFF, 64'h0, 1'b0, 12'h0, 64'h0, w);
        @(posedge clk);
        #1;
        checkReg(5'd1);
        checkReg(5'd0);

        // csr writes with masking and an unsupported address.
        sendEntry(64'h2000, 5'd0, WB_ALU, 1'b0, 64'h0, 64'h0, 1'b1, CSR_MTVEC,
                  64'hFFFF_0000_1234_567F, w);
        sendEntry(64'h2004, 5'd0, WB_ALU, 1'b0, 64'h0, 64'h0, 1'b1, CSR_MSCRATCH,
                  64'hDEAD_BEEF_CAFE_F00D, w);
        sendEntry(64'h2008, 5'd0, WB_ALU, 1'b0, 64'h0, 64'h0, 1'b1, CSR_MEPC,
                  64'h0000_0000_8000_0003, w);
        sendEntry(64'h200c, 5'd0, WB_ALU, 1'b0, 64'h0, 64'h0, 1'b1, 12'h300,
                  64'h1111_2222_3333_4444, w);
        @(posedge clk);
        #1;
        checkCsr(CSR_MTVEC);
        checkCsr(CSR_MSCRATCH);
        checkCsr(CSR_MEPC);
        checkCsr(12'h300);

        // random entries under back-pressure.
        stallMode = 1'b1;
        for (int i = 0; i < 200; i++) begin
            nextData(r0);
            nextData(r1);
            nextData(r2);
            s = (r0[1:0] == 2'd3) ? WB_ALU : wbSrcE'(r0[1:0]);
            case (r0[9:8])
                2'd0: ca = CSR_MTVEC;
                2'd1: ca = CSR_MSCRATCH;
                2'd2: ca = CSR_MEPC;
                default: ca = 12'h7c0;
            endcase
            sendEntry({32'h0, r1 & 32'hffff_fffc}, r0[6:2], s, r0[7],
                      {r1, r2}, {r2, r1}, r0[12:10] == 3'd0, ca, {r2, r0}, w);
        end
        stallMode = 1'b0;
        @(posedge clk);
        #1;
        drain();
        for (int i = 0; i < 32; i++) checkReg(i[4:0]);
        checkCsr(CSR_MTVEC);
        checkCsr(CSR_MSCRATCH);
        checkCsr(CSR_MEPC);

        // full rate with commitReady held high.
        commitReady = 1'b1;
        for (int i = 0; i < 8; i++) begin
            sendEntry(64'h3000 + 64'(i * 4), 5'(i + 8), WB_ALU, 1'b1, 64'(i), 64'h0,
                      1'b0, 12'h0, 64'h0, w);
            checkVal("throughput stall cycles", 64'h0, 64'(w));
            checkVal("throughput commitValid", 64'h1, {63'h0, commitValid});
            checkVal("throughput commitPc", 64'h3000 + 64'(i * 4), commitPc);
        end
        drain();
        repeat (2) @(posedge clk);

        $display("%0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/wbPkg.sv
design/writebackStage.sv
design/regFile.sv
design/csrFile.sv
design/wbTop.sv
tests/tbClock.sv
tests/wbAsserts.sv
tests/wbTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= wbTb
OBJ_DIR ?= obj_dir
FILELIST ?= build.f
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Finished with no errors

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
